//--- design/fas_config.svh
`ifndef FAS_CONFIG_SVH
`define FAS_CONFIG_SVH

// input sample width
`define FAS_SAMPLE_W 16

// frame length and its log2
`define FAS_POINTS 16
`define FAS_STAGES 4

// one part of a bin, sample width plus one bit per stage
`define FAS_BIN_W 20

// twiddles in Q1.14, 1.0 is 16384
`define FAS_TW_W 16
`define FAS_TW_FRAC 14

// peak search over bins 0..8, result width
`define FAS_PEAK_BINS 9
`define FAS_FREQ_W 4

`endif

//--- design/fas_pkg.sv
`include "fas_config.svh"

package fas_pkg;

  // raw input sample
  typedef logic signed [`FAS_SAMPLE_W-1:0] sample_t;

  // one complex value, both parts at full bin width
  typedef struct packed {
    logic signed [`FAS_BIN_W-1:0] re;
    logic signed [`FAS_BIN_W-1:0] im;
  } cplx_t;

  // whole frame, element 0 is the first sample
  // also used for the natural-order bins at the output
  typedef cplx_t [`FAS_POINTS-1:0] frame_t;

  // index of the strongest bin
  typedef logic [`FAS_FREQ_W-1:0] freq_t;

endpackage

//--- design/sample_collector.sv
`timescale 1ns/1ns
`include "fas_config.svh"

module sample_collector (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output fas_pkg::frame_t  frame,
  output logic             frame_valid
);

  import fas_pkg::*;

  localparam int cnt_w = $clog2(`FAS_POINTS);

  logic [cnt_w-1:0] count;
  cplx_t            new_elem;
  logic             last_sample;

  // real sample, sign extended, imaginary part zero
  always_comb
  begin
    new_elem.re = {{(`FAS_BIN_W - `FAS_SAMPLE_W){data[`FAS_SAMPLE_W-1]}}, data};
    new_elem.im = '0;
  end

  assign last_sample = data_valid && (count == cnt_w'(`FAS_POINTS - 1));

  // samples move down, newest enters at the top
  always_ff @(posedge clk)
  begin
    if (data_valid)
    begin
      for (int i = 0; i < `FAS_POINTS - 1; i++)
      begin
        frame[i] <= frame[i + 1];
      end
      frame[`FAS_POINTS-1] <= new_elem;
    end
  end

  // wraps to zero after the last sample of a frame
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (data_valid)
    begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= last_sample;
    end
  end

  // a frame needs 16 accepted samples, so strobes never touch
  a_single_strobe: assert property (
    @(posedge clk) disable iff (rst)
    frame_valid |=> !frame_valid
  ) else $error("frame_valid high on two cycles in a row");

endmodule

//--- design/fft_stage.sv
`timescale 1ns/1ns
`include "fas_config.svh"

module fft_stage #(
  parameter int stage = 0
) (
  input  logic            clk,
  input  logic            rst,
  input  fas_pkg::frame_t in_frame,
  input  logic            in_valid,
  output fas_pkg::frame_t out_frame,
  output logic            out_valid
);

  import fas_pkg::*;

  // butterfly span within a group at this stage
  localparam int half = `FAS_POINTS >> (stage + 1);
  localparam int prod_w = `FAS_BIN_W + `FAS_TW_W + 1;

  // W16^k for k = 0..7, cosine and minus sine
  localparam logic signed [`FAS_TW_W-1:0] cos_tab [`FAS_POINTS/2] = '{
    16'sd16384, 16'sd15137, 16'sd11585, 16'sd6270,
    16'sd0, -16'sd6270, -16'sd11585, -16'sd15137
  };
  localparam logic signed [`FAS_TW_W-1:0] msin_tab [`FAS_POINTS/2] = '{
    16'sd0, -16'sd6270, -16'sd11585, -16'sd15137,
    -16'sd16384, -16'sd15137, -16'sd11585, -16'sd6270
  };

  frame_t nxt;

  // complex multiply by a twiddle, truncated back to Q0
  function automatic cplx_t rotate(input cplx_t d, input int pw);
    logic signed [prod_w-1:0] prod_re;
    logic signed [prod_w-1:0] prod_im;
    cplx_t                    r;
    prod_re = d.re * cos_tab[pw] - d.im * msin_tab[pw];
    prod_im = d.re * msin_tab[pw] + d.im * cos_tab[pw];
    prod_re = prod_re >>> `FAS_TW_FRAC;
    prod_im = prod_im >>> `FAS_TW_FRAC;
    r.re = prod_re[`FAS_BIN_W-1:0];
    r.im = prod_im[`FAS_BIN_W-1:0];
    return r;
  endfunction

  always_comb
  begin
    int    lo;
    int    hi;
    int    pw;
    cplx_t a;
    cplx_t b;
    cplx_t d;
    nxt = '0;
    for (int p = 0; p < `FAS_POINTS / 2; p++)
    begin
      lo = (p / half) * 2 * half + (p % half);
      hi = lo + half;
      pw = (p % half) << stage;
      a = in_frame[lo];
      b = in_frame[hi];
      nxt[lo].re = a.re + b.re;
      nxt[lo].im = a.im + b.im;
      d.re = a.re - b.re;
      d.im = a.im - b.im;
      // DIF, twiddle goes on the difference leg
      nxt[hi] = rotate(d, pw);
    end
  end

  always_ff @(posedge clk)
  begin
    out_frame <= nxt;
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      out_valid <= 1'b0;
    end
    else
    begin
      out_valid <= in_valid;
    end
  end

  a_latency: assert property (
    @(posedge clk) disable iff (rst)
    out_valid == $past(in_valid)
  ) else $error("stage %0d valid is not in_valid delayed by one", stage);

endmodule

//--- design/peak_finder.sv
`timescale 1ns/1ns
`include "fas_config.svh"

module peak_finder (
  input  logic            clk,
  input  logic            rst,
  input  fas_pkg::frame_t fft_bins,
  input  logic            fft_valid,
  output fas_pkg::freq_t  freq,
  output logic            done
);

  import fas_pkg::*;

  localparam int mag_w = 2 * `FAS_BIN_W + 1;

  // magnitude squared travels with its bin index
  typedef struct packed {
    logic [mag_w-1:0] mag;
    freq_t            idx;
  } cand_t;

  cand_t cand [`FAS_PEAK_BINS];
  cand_t lvl1 [4];
  cand_t lvl2 [2];
  cand_t lvl3;
  cand_t win;

  // left operand always holds the lower indices, so it keeps ties
  function automatic cand_t better(input cand_t a, input cand_t b);
    return (b.mag > a.mag) ? b : a;
  endfunction

  always_comb
  begin
    logic signed [2*`FAS_BIN_W-1:0] sq_re;
    logic signed [2*`FAS_BIN_W-1:0] sq_im;
    for (int i = 0; i < `FAS_PEAK_BINS; i++)
    begin
      sq_re = fft_bins[i].re * fft_bins[i].re;
      sq_im = fft_bins[i].im * fft_bins[i].im;
      cand[i].mag = mag_w'($unsigned(sq_re)) + mag_w'($unsigned(sq_im));
      cand[i].idx = freq_t'(i);
    end
  end

  // 9 -> 5 -> 3 -> 2 -> 1, bin 8 joins last
  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      lvl1[k] = better(cand[2*k], cand[2*k+1]);
    end
    lvl2[0] = better(lvl1[0], lvl1[1]);
    lvl2[1] = better(lvl1[2], lvl1[3]);
    lvl3 = better(lvl2[0], lvl2[1]);
    win = better(lvl3, cand[`FAS_PEAK_BINS-1]);
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      freq <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= fft_valid;
      if (fft_valid)
      begin
        freq <= win.idx;
      end
    end
  end

  // mirrored half of the spectrum is never reported
  a_freq_range: assert property (
    @(posedge clk) disable iff (rst)
    done |-> (freq <= freq_t'(`FAS_PEAK_BINS - 1))
  ) else $error("freq %0d outside searched bins", freq);

endmodule

//--- design/fas_top.sv
`timescale 1ns/1ns
`include "fas_config.svh"

module fas_top (
  input  logic             clk,
  input  logic             rst,
  input  logic             data_valid,
  input  fas_pkg::sample_t data,
  output fas_pkg::frame_t  fft_bins,
  output logic             fft_valid,
  output logic             done,
  output fas_pkg::freq_t   freq
);

  import fas_pkg::*;

  // index 0 is the collector, index k+1 is stage k
  frame_t                stage_frame [`FAS_STAGES+1];
  logic [`FAS_STAGES:0]  stage_valid;

  function automatic int bit_rev(input int k);
    int r;
    r = 0;
    for (int b = 0; b < `FAS_STAGES; b++)
    begin
      r = r | (((k >> b) & 1) << (`FAS_STAGES - 1 - b));
    end
    return r;
  endfunction

  sample_collector u_collector (
    .clk         (clk),
    .rst         (rst),
    .data_valid  (data_valid),
    .data        (data),
    .frame       (stage_frame[0]),
    .frame_valid (stage_valid[0])
  );

  for (genvar s = 0; s < `FAS_STAGES; s++)
  begin : g_stage
    fft_stage #(.stage(s)) u_stage (
      .clk       (clk),
      .rst       (rst),
      .in_frame  (stage_frame[s]),
      .in_valid  (stage_valid[s]),
      .out_frame (stage_frame[s+1]),
      .out_valid (stage_valid[s+1])
    );
  end

  // last stage leaves bins in bit-reversed order
  always_comb
  begin
    for (int k = 0; k < `FAS_POINTS; k++)
    begin
      fft_bins[k] = stage_frame[`FAS_STAGES][bit_rev(k)];
    end
  end

  assign fft_valid = stage_valid[`FAS_STAGES];

  peak_finder u_peak (
    .clk       (clk),
    .rst       (rst),
    .fft_bins  (fft_bins),
    .fft_valid (fft_valid),
    .freq      (freq),
    .done      (done)
  );

endmodule

//--- bench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
  parameter int period       = 8,
  parameter int reset_cycles = 3
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;
  end

  // released on a falling edge, away from the sampling edge
  initial
  begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  end

endmodule

//--- bench/fas_tb.sv
`timescale 1ns/1ns
`include "fas_config.svh"

module fas_tb;

  import fas_pkg::*;

  localparam logic [1:0] kind_dc  = 2'd0;
  localparam logic [1:0] kind_alt = 2'd1;
  localparam logic [1:0] kind_imp = 2'd2;

  localparam int n_directed  = 3;
  localparam int n_gapped    = 6;
  localparam int n_burst     = 6;
  localparam int n_frames    = n_directed + n_gapped + n_burst;
  localparam int cycle_limit = n_frames * 40 + 100;

  // what one frame should produce
  typedef struct packed {
    logic [1:0] kind;
    sample_t    amp;
    logic       b2b;
  } exp_t;

  logic    clk;
  logic    rst;
  logic    data_valid;
  sample_t data;
  frame_t  fft_bins;
  logic    fft_valid;
  logic    done;
  freq_t   freq;

  // high while the 16th sample of a frame is on the bus
  logic    last_accept;

  exp_t    exp_q [$];
  exp_t    exp_cur;
  logic    have_exp;
  frame_t  exp_bins;
  freq_t   exp_freq;
  logic    done_seen;

  int      seed;
  int      errors;
  int      pulses;
  int      frames_sent;
  int      gap_cnt;
  // cycles between the last two fft_valid pulses
  int      spacing;
  int      cycles;

  tb_clock u_clock (
    .clk (clk),
    .rst (rst)
  );

  fas_top dut (
    .clk        (clk),
    .rst        (rst),
    .data_valid (data_valid),
    .data       (data),
    .fft_bins   (fft_bins),
    .fft_valid  (fft_valid),
    .done       (done),
    .freq       (freq)
  );

  function automatic void note_error(input string msg);
    errors++;
    $display("** Error: %0t ns: %s", $time, msg);
  endfunction

  function automatic sample_t sample_for(input logic [1:0] kind, input sample_t amp,
                                         input int n);
    sample_t s;
    case (kind)
      kind_dc:  s = amp;
      kind_alt: s = (n % 2 == 0) ? amp : -amp;
      default:  s = (n == 0) ? amp : '0;
    endcase
    return s;
  endfunction

  // DFT of each frame kind worked out by hand
  function automatic frame_t bins_for(input exp_t e);
    frame_t                       b;
    logic signed [`FAS_BIN_W-1:0] a;
    b = '0;
    a = e.amp;
    case (e.kind)
      kind_dc:  b[0].re = a <<< `FAS_STAGES;
      kind_alt: b[`FAS_POINTS/2].re = a <<< `FAS_STAGES;
      default:
      begin
        // flat spectrum
        for (int k = 0; k < `FAS_POINTS; k++)
        begin
          b[k].re = a;
        end
      end
    endcase
    return b;
  endfunction

  // impulse ties on every bin, lowest index wins
  function automatic freq_t freq_for(input exp_t e);
    return (e.kind == kind_alt) ? freq_t'(`FAS_POINTS / 2) : freq_t'(0);
  endfunction

  function automatic sample_t random_amp();
    int r;
    r = $random(seed) % 16384;
    if (r == 0)
    begin
      r = 1;
    end
    return sample_t'(r);
  endfunction

  function automatic logic [1:0] random_kind();
    int r;
    r = $unsigned($random(seed)) % 3;
    return r[1:0];
  endfunction

  assign exp_bins = bins_for(exp_cur);
  assign exp_freq = freq_for(exp_cur);

  task automatic idle(input int n);
    data_valid  = 1'b0;
    last_accept = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  // starts and ends on a falling edge
  task automatic send_frame(input logic [1:0] kind, input sample_t amp,
                            input bit gaps, input bit b2b);
    exp_t e;
    int   wait_n;
    for (int n = 0; n < `FAS_POINTS; n++)
    begin
      if (gaps)
      begin
        wait_n = $random(seed) & 1;
        idle(wait_n);
      end
      data_valid  = 1'b1;
      data        = sample_for(kind, amp, n);
      last_accept = (n == `FAS_POINTS - 1);
      @(negedge clk);
    end
    e.kind = kind;
    e.amp  = amp;
    e.b2b  = b2b;
    exp_q.push_back(e);
    frames_sent++;
    data_valid  = 1'b0;
    last_accept = 1'b0;
  endtask

  task automatic finish_run(input bit timed_out);
    $display("frames sent %0d, fft_valid pulses %0d, errors %0d, timeout %0b",
             frames_sent, pulses, errors, timed_out);
    if (errors == 0 && !timed_out)
    begin
      $display("PASS: all tests");
    end
    else
    begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // bench side bookkeeping, all on the falling edge
  always @(negedge clk)
  begin
    if (fft_valid)
    begin
      pulses++;
      spacing = gap_cnt;
      gap_cnt = 1;
    end
    else
    begin
      gap_cnt++;
    end
    // a frame retires the cycle after its done pulse
    if (done_seen && exp_q.size() != 0)
    begin
      void'(exp_q.pop_front());
    end
    done_seen = done;
    have_exp = (exp_q.size() != 0);
    if (have_exp)
    begin
      exp_cur = exp_q[0];
    end
  end

  a_reset_quiet: assert property (
    @(posedge clk)
    (rst || $past(rst)) |-> (!fft_valid && !done && freq == freq_t'(0))
  ) else note_error("outputs not idle during or right after reset");

  a_frame_known: assert property (
    @(posedge clk) disable iff (rst)
    fft_valid |-> have_exp
  ) else note_error("fft_valid pulse with no frame outstanding");

  a_bins: assert property (
    @(posedge clk) disable iff (rst)
    (fft_valid && have_exp) |-> (fft_bins == exp_bins)
  ) else note_error($sformatf("bins wrong for kind %0d amplitude %0d",
                              exp_cur.kind, exp_cur.amp));

  a_freq: assert property (
    @(posedge clk) disable iff (rst)
    (done && have_exp) |-> (freq == exp_freq)
  ) else note_error($sformatf("freq %0d, expected %0d for kind %0d",
                              freq, exp_freq, exp_cur.kind));

  // 16th sample sampled at E0, fft_valid sampled at E0 + 5
  a_latency: assert property (
    @(posedge clk) disable iff (rst)
    fft_valid == $past(last_accept, 5)
  ) else note_error("fft_valid not 4 cycles after the 16th sample");

  a_done_follows: assert property (
    @(posedge clk) disable iff (rst)
    done == $past(fft_valid)
  ) else note_error("done not 1 cycle after fft_valid");

  a_spacing: assert property (
    @(posedge clk) disable iff (rst)
    (fft_valid && have_exp && exp_cur.b2b) |-> (spacing == `FAS_POINTS)
  ) else note_error($sformatf("back-to-back pulses %0d cycles apart", spacing));

  initial
  begin
    cycles = 0;
    while (cycles < cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", cycle_limit);
    finish_run(1'b1);
  end

  initial
  begin
    seed        = 32'hcd55;
    errors      = 0;
    pulses      = 0;
    frames_sent = 0;
    gap_cnt     = 0;
    spacing     = 0;
    done_seen   = 1'b0;
    have_exp    = 1'b0;
    exp_cur     = '0;
    data_valid  = 1'b0;
    data        = '0;
    last_accept = 1'b0;
    @(negedge rst);
    idle(3);
    send_frame(kind_dc, 16'sd1000, 1'b0, 1'b0);
    idle(4);
    send_frame(kind_alt, -16'sd1234, 1'b0, 1'b0);
    idle(4);
    send_frame(kind_imp, 16'sd20000, 1'b0, 1'b0);
    idle(10);
    // random holes in data_valid
    for (int f = 0; f < n_gapped; f++)
    begin
      send_frame(random_kind(), random_amp(), 1'b1, 1'b0);
    end
    idle(10);
    for (int f = 0; f < n_burst; f++)
    begin
      send_frame(2'(f % 3), random_amp(), 1'b0, f != 0);
    end
    while (exp_q.size() != 0)
    begin
      @(negedge clk);
    end
    // room for a stray pulse
    idle(20);
    a_pulse_count: assert (pulses == frames_sent)
      else note_error($sformatf("%0d fft_valid pulses for %0d frames", pulses, frames_sent));
    finish_run(1'b0);
  end

endmodule

//--- vlog.f
+incdir+design
design/fas_pkg.sv
design/sample_collector.sv
design/fft_stage.sv
design/peak_finder.sv
design/fas_top.sv
bench/tb_clock.sv
bench/fas_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= fas_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
